//--- design/cpuPkg.sv
package cpuPkg;

	// machine sizes
	localparam int wordWidth = 32;
	localparam int regCount = 16;
	localparam int regSelWidth = 4; // width of Ra, Rb, Rc fields
	localparam int memWords = 512;
	localparam int memAddrWidth = 9;

	// instruction field positions
	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 27;
	localparam int raLsb = 23;
	localparam int rbLsb = 19;
	localparam int rcLsb = 15;
	localparam int constMsb = 18; // C sits in 18..0, sign extended
	localparam int condMsb = 20; // branch condition code
	localparam int condLsb = 19;
	localparam int linkRegister = 15; // return address for jal

	// opcodes in instruction set order, 0 to 27
	typedef enum logic [4:0] {
		opLd, opLdi, opSt, opAdd, opSub, opAnd, opOr, opShr, opShra, opShl,
		opRor, opRol, opAddi, opAndi, opOri, opMul, opDiv, opNeg, opNot, opBr,
		opJr, opJal, opIn, opOut, opMfhi, opMflo, opNop, opHalt
	} opcodeT;

	// steps of each class are contiguous so most steps fall through by +1
	typedef enum logic [7:0] {
		stReset,
		stFetch0, stFetch1, stFetch2, stFetch3,
		stLd0, stLd1, stLd2, stLd3, stLd4,
		stLdi0, stLdi1, stLdi2,
		stSt0, stSt1, stSt2, stSt3, stSt4,
		stAluReg0, stAluReg1, stAluReg2,
		stAluImm0, stAluImm1, stAluImm2,
		stMulDiv0, stMulDiv1, stMulDivWait, stMulDiv2, stMulDiv3,
		stUnary0, stUnary1,
		stBr0, stBr1, stBr2, stBr3,
		stJr, stJal0, stJal1, stIn, stOut, stMfhi, stMflo,
		stNop0, stNop1, stNop2, stNop3, stNop4,
		stHalt
	} stateT;

	// one driver on the bus at a time
	typedef enum logic [3:0] {
		srcNone, srcReg, srcPc, srcMdr, srcRzLo, srcRzHi, srcHi, srcLo, srcImm, srcInPort
	} busSourceT;

	typedef struct packed {
		busSourceT busSource;
		logic regA; // register select from Ra
		logic regB;
		logic regC;
		logic regIn;
		logic baseAddr; // R0 reads as zero
		logic pcIn;
		logic incPc;
		logic irIn;
		logic mdrIn;
		logic memRead; // MDR takes memory instead of bus
		logic marIn;
		logic ryIn;
		logic rzIn;
		logic hiIn;
		logic loIn;
		logic condIn;
		logic outPortIn;
		logic memWrite;
		opcodeT aluOp;
		logic aluStart;
	} controlWordT;

endpackage

//--- design/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic clock,
	input  logic reset,
	input  logic [cpuPkg::wordWidth-1:0] ir,
	input  logic branchTaken,
	input  logic aluDone,
	output cpuPkg::controlWordT control,
	output logic halted,
	output logic [15:0] instrCount
);

	cpuPkg::stateT state;
	cpuPkg::stateT nextState;
	cpuPkg::stateT decodeState;
	cpuPkg::opcodeT opcode;

	assign opcode = cpuPkg::opcodeT'(ir[cpuPkg::opcodeMsb:cpuPkg::opcodeLsb]);
	assign halted = (state == cpuPkg::stHalt); // halt loops on itself until reset

	// first step of each instruction class
	always_comb begin
		case (opcode)
			cpuPkg::opLd: decodeState = cpuPkg::stLd0;
			cpuPkg::opLdi: decodeState = cpuPkg::stLdi0;
			cpuPkg::opSt: decodeState = cpuPkg::stSt0;
			cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr, cpuPkg::opShr,
			cpuPkg::opShra, cpuPkg::opShl, cpuPkg::opRor, cpuPkg::opRol:
				decodeState = cpuPkg::stAluReg0;
			cpuPkg::opAddi, cpuPkg::opAndi, cpuPkg::opOri: decodeState = cpuPkg::stAluImm0;
			cpuPkg::opMul, cpuPkg::opDiv: decodeState = cpuPkg::stMulDiv0;
			cpuPkg::opNeg, cpuPkg::opNot: decodeState = cpuPkg::stUnary0;
			cpuPkg::opBr: decodeState = cpuPkg::stBr0;
			cpuPkg::opJr: decodeState = cpuPkg::stJr;
			cpuPkg::opJal: decodeState = cpuPkg::stJal0;
			cpuPkg::opIn: decodeState = cpuPkg::stIn;
			cpuPkg::opOut: decodeState = cpuPkg::stOut;
			cpuPkg::opMfhi: decodeState = cpuPkg::stMfhi;
			cpuPkg::opMflo: decodeState = cpuPkg::stMflo;
			cpuPkg::opHalt: decodeState = cpuPkg::stHalt;
			default: decodeState = cpuPkg::stNop0; // nop and unused codes
		endcase
	end

	always_comb begin
		nextState = cpuPkg::stateT'(state + 8'd1); // default is the following step
		case (state)
			cpuPkg::stFetch3: nextState = decodeState;
			cpuPkg::stLd4, cpuPkg::stLdi2, cpuPkg::stSt4, cpuPkg::stAluReg2, cpuPkg::stAluImm2,
			cpuPkg::stMulDiv3, cpuPkg::stUnary1, cpuPkg::stBr3, cpuPkg::stNop4:
				nextState = cpuPkg::stFetch0;
			cpuPkg::stMulDivWait: if (!aluDone) nextState = cpuPkg::stMulDivWait;
			// short ones padded out by the nop chain
			cpuPkg::stJr, cpuPkg::stIn, cpuPkg::stOut, cpuPkg::stMfhi, cpuPkg::stMflo:
				nextState = cpuPkg::stNop1;
			cpuPkg::stJal1: nextState = cpuPkg::stNop2;
			cpuPkg::stHalt: nextState = cpuPkg::stHalt;
			default: ;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= cpuPkg::stReset;
			instrCount <= '0;
		end else begin
			state <= nextState;
			if (state == cpuPkg::stFetch1)
				instrCount <= instrCount + 16'd1; // one count per fetch
		end
	end

	always_comb begin
		control = '0;
		case (state)
			cpuPkg::stFetch0: begin
				control.busSource = cpuPkg::srcPc;
				control.marIn = 1'b1;
				control.incPc = 1'b1; // MAR gets old PC
			end
			cpuPkg::stFetch1, cpuPkg::stLd3: begin
				control.memRead = 1'b1;
				control.mdrIn = 1'b1;
			end
			cpuPkg::stFetch2: begin
				control.busSource = cpuPkg::srcMdr;
				control.irIn = 1'b1;
			end
			cpuPkg::stLd0, cpuPkg::stLdi0, cpuPkg::stSt0: begin
				control.busSource = cpuPkg::srcReg;
				control.regB = 1'b1;
				control.baseAddr = 1'b1; // Rb of R0 means absolute
				control.ryIn = 1'b1;
			end
			cpuPkg::stAluReg0, cpuPkg::stAluImm0: begin
				control.busSource = cpuPkg::srcReg;
				control.regB = 1'b1;
				control.ryIn = 1'b1;
			end
			cpuPkg::stLd1, cpuPkg::stLdi1, cpuPkg::stSt1, cpuPkg::stBr2, cpuPkg::stAluImm1: begin
				control.busSource = cpuPkg::srcImm;
				control.rzIn = 1'b1;
				control.aluOp = (state == cpuPkg::stAluImm1) ? opcode : cpuPkg::opAdd;
				control.aluStart = 1'b1;
			end
			cpuPkg::stAluReg1, cpuPkg::stUnary0: begin
				control.busSource = cpuPkg::srcReg;
				control.regC = (state == cpuPkg::stAluReg1);
				control.regB = (state == cpuPkg::stUnary0); // unary ops only see the bus
				control.rzIn = 1'b1;
				control.aluOp = opcode;
				control.aluStart = 1'b1;
			end
			cpuPkg::stLd2, cpuPkg::stSt2: begin
				control.busSource = cpuPkg::srcRzLo; // effective address
				control.marIn = 1'b1;
			end
			cpuPkg::stLd4: begin
				control.busSource = cpuPkg::srcMdr;
				control.regA = 1'b1;
				control.regIn = 1'b1;
			end
			cpuPkg::stLdi2, cpuPkg::stAluReg2, cpuPkg::stAluImm2, cpuPkg::stUnary1: begin
				control.busSource = cpuPkg::srcRzLo;
				control.regA = 1'b1;
				control.regIn = 1'b1;
			end
			cpuPkg::stSt3: begin
				control.busSource = cpuPkg::srcReg;
				control.regA = 1'b1;
				control.mdrIn = 1'b1;
			end
			cpuPkg::stSt4: control.memWrite = 1'b1;
			cpuPkg::stMulDiv0: begin
				control.busSource = cpuPkg::srcReg;
				control.regA = 1'b1;
				control.ryIn = 1'b1;
			end
			cpuPkg::stMulDiv1: begin
				control.busSource = cpuPkg::srcReg;
				control.regB = 1'b1;
				control.aluOp = opcode;
				control.aluStart = 1'b1; // operands latched here
			end
			cpuPkg::stMulDivWait: begin
				control.rzIn = 1'b1; // RZ holds the final value once done
				control.aluOp = opcode;
			end
			cpuPkg::stMulDiv2: begin
				control.busSource = cpuPkg::srcRzHi;
				control.hiIn = 1'b1;
			end
			cpuPkg::stMulDiv3: begin
				control.busSource = cpuPkg::srcRzLo;
				control.loIn = 1'b1;
			end
			cpuPkg::stBr0: begin
				control.busSource = cpuPkg::srcReg;
				control.regA = 1'b1;
				control.condIn = 1'b1;
			end
			cpuPkg::stBr1: begin
				control.busSource = cpuPkg::srcPc;
				control.ryIn = 1'b1;
			end
			cpuPkg::stBr3: begin
				if (branchTaken) begin
					control.busSource = cpuPkg::srcRzLo; // PC + C
					control.pcIn = 1'b1;
				end
			end
			cpuPkg::stJr, cpuPkg::stJal1: begin
				control.busSource = cpuPkg::srcReg;
				control.regA = 1'b1;
				control.pcIn = 1'b1;
			end
			cpuPkg::stJal0: begin
				control.busSource = cpuPkg::srcPc;
				control.regIn = 1'b1; // register file steers this to R15
			end
			cpuPkg::stIn: begin
				control.busSource = cpuPkg::srcInPort;
				control.regA = 1'b1;
				control.regIn = 1'b1;
			end
			cpuPkg::stOut: begin
				control.busSource = cpuPkg::srcReg;
				control.regA = 1'b1;
				control.outPortIn = 1'b1;
			end
			cpuPkg::stMfhi, cpuPkg::stMflo: begin
				control.busSource = (state == cpuPkg::stMfhi) ? cpuPkg::srcHi : cpuPkg::srcLo;
				control.regA = 1'b1;
				control.regIn = 1'b1;
			end
			default: ; // reset, fetch3, nop chain and halt are idle
		endcase
	end

	// encoding stays within the defined steps
	assert property (@(posedge clock) disable iff (reset) state <= cpuPkg::stHalt);

	// no restart of the ALU while a mul or div is still running
	assert property (@(posedge clock) disable iff (reset)
		(state == cpuPkg::stMulDivWait || !aluDone) |-> !control.aluStart);

endmodule

//--- design/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic clock,
	input  logic reset,
	input  cpuPkg::controlWordT control,
	input  logic [cpuPkg::wordWidth-1:0] ir,
	input  logic [cpuPkg::wordWidth-1:0] bus,
	output logic [cpuPkg::wordWidth-1:0] regOut
);

	logic [cpuPkg::wordWidth-1:0] regs [cpuPkg::regCount];
	logic [cpuPkg::regSelWidth-1:0] sel;
	logic isJal;

	assign isJal = (ir[cpuPkg::opcodeMsb:cpuPkg::opcodeLsb] == cpuPkg::opJal);

	always_comb begin
		if (isJal && control.regIn)
			sel = cpuPkg::linkRegister[cpuPkg::regSelWidth-1:0]; // link write
		else if (control.regA)
			sel = ir[cpuPkg::raLsb +: cpuPkg::regSelWidth];
		else if (control.regB)
			sel = ir[cpuPkg::rbLsb +: cpuPkg::regSelWidth];
		else if (control.regC)
			sel = ir[cpuPkg::rcLsb +: cpuPkg::regSelWidth];
		else
			sel = '0; // no select raised
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < cpuPkg::regCount; i++)
				regs[i] <= '0;
		end else if (control.regIn) begin
			regs[sel] <= bus;
		end
	end

	// base addressing treats R0 as a zero base
	assign regOut = (control.baseAddr && sel == '0) ? '0 : regs[sel];

endmodule

//--- design/busDatapath.sv
`timescale 1ns/1ps

module busDatapath (
	input  logic clock,
	input  logic reset,
	input  cpuPkg::controlWordT control,
	input  logic [cpuPkg::wordWidth-1:0] regOut,
	input  logic [2*cpuPkg::wordWidth-1:0] aluResult,
	input  logic [cpuPkg::wordWidth-1:0] memData,
	input  logic [cpuPkg::wordWidth-1:0] inPort,
	output logic [cpuPkg::wordWidth-1:0] bus,
	output logic [cpuPkg::wordWidth-1:0] ir,
	output logic [cpuPkg::wordWidth-1:0] ry,
	output logic [cpuPkg::memAddrWidth-1:0] mar,
	output logic [cpuPkg::wordWidth-1:0] mdr,
	output logic branchTaken,
	output logic [cpuPkg::wordWidth-1:0] outPort,
	output logic outStrobe
);

	logic [cpuPkg::wordWidth-1:0] pc;
	logic [2*cpuPkg::wordWidth-1:0] rz; // full 64-bit ALU result
	logic [cpuPkg::wordWidth-1:0] hi;
	logic [cpuPkg::wordWidth-1:0] lo;
	logic [cpuPkg::wordWidth-1:0] inReg; // input port register
	logic [cpuPkg::wordWidth-1:0] immediate;
	logic condMet;

	assign immediate = {{(cpuPkg::wordWidth - cpuPkg::constMsb - 1){ir[cpuPkg::constMsb]}},
		ir[cpuPkg::constMsb:0]};

	always_comb begin
		case (control.busSource)
			cpuPkg::srcReg: bus = regOut;
			cpuPkg::srcPc: bus = pc;
			cpuPkg::srcMdr: bus = mdr;
			cpuPkg::srcRzLo: bus = rz[cpuPkg::wordWidth-1:0];
			cpuPkg::srcRzHi: bus = rz[2*cpuPkg::wordWidth-1:cpuPkg::wordWidth];
			cpuPkg::srcHi: bus = hi;
			cpuPkg::srcLo: bus = lo;
			cpuPkg::srcImm: bus = immediate;
			cpuPkg::srcInPort: bus = inReg;
			default: bus = '0; // nothing selected
		endcase
	end

	// condition tested on Ra while it sits on the bus
	always_comb begin
		case (ir[cpuPkg::condMsb:cpuPkg::condLsb])
			2'd0: condMet = (bus == '0);
			2'd1: condMet = (bus != '0);
			2'd2: condMet = !bus[cpuPkg::wordWidth-1] && (bus != '0);
			default: condMet = bus[cpuPkg::wordWidth-1];
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
			branchTaken <= 1'b0;
			outPort <= '0;
			outStrobe <= 1'b0;
		end else begin
			if (control.pcIn)
				pc <= bus;
			else if (control.incPc)
				pc <= pc + 1'b1; // word addressed
			if (control.irIn)
				ir <= bus;
			if (control.condIn)
				branchTaken <= condMet;
			if (control.outPortIn)
				outPort <= bus;
			outStrobe <= control.outPortIn; // valid with the new outPort value
		end
	end

	always_ff @(posedge clock) begin
		inReg <= inPort;
		if (control.marIn)
			mar <= bus[cpuPkg::memAddrWidth-1:0];
		if (control.mdrIn)
			mdr <= control.memRead ? memData : bus;
		if (control.ryIn)
			ry <= bus;
		if (control.rzIn)
			rz <= aluResult;
		if (control.hiIn)
			hi <= bus;
		if (control.loIn)
			lo <= bus;
	end

	// MAR and PC share fetch0 timing, never loaded together
	assert property (@(posedge clock) disable iff (reset) !(control.marIn && control.pcIn));

endmodule

//--- design/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input  logic clock,
	input  logic reset,
	input  cpuPkg::controlWordT control,
	input  logic [cpuPkg::wordWidth-1:0] ry,
	input  logic [cpuPkg::wordWidth-1:0] bus,
	output logic [2*cpuPkg::wordWidth-1:0] aluResult,
	output logic aluDone
);

	logic [cpuPkg::wordWidth-1:0] accHi; // product high or remainder
	logic [cpuPkg::wordWidth-1:0] accLo; // product low or quotient
	logic [cpuPkg::wordWidth-1:0] operand; // magnitude of multiplicand or divisor
	logic [cpuPkg::wordWidth-1:0] magA;
	logic [cpuPkg::wordWidth-1:0] magB;
	logic [cpuPkg::wordWidth-1:0] single;
	logic [cpuPkg::wordWidth:0] mulSum;
	logic [cpuPkg::wordWidth:0] remShift;
	logic [cpuPkg::wordWidth:0] divDiff;
	logic [2*cpuPkg::wordWidth-1:0] mulDivResult;
	logic [5:0] stepCount;
	logic [5:0] rotBack;
	logic [4:0] shiftAmount;
	logic negHi;
	logic negLo;
	logic isDiv;
	logic isMulDiv;

	assign isDiv = (control.aluOp == cpuPkg::opDiv);
	assign isMulDiv = isDiv || (control.aluOp == cpuPkg::opMul);
	assign shiftAmount = bus[4:0];
	assign rotBack = 6'd32 - {1'b0, shiftAmount}; // 32 shifts out fully, so ror 0 is safe
	assign magA = ry[cpuPkg::wordWidth-1] ? -ry : ry;
	assign magB = bus[cpuPkg::wordWidth-1] ? -bus : bus;

	assign mulSum = {1'b0, accHi} + (accLo[0] ? {1'b0, operand} : '0);
	assign remShift = {accHi, accLo[cpuPkg::wordWidth-1]};
	assign divDiff = remShift - {1'b0, operand};

	always_ff @(posedge clock or posedge reset) begin
		if (reset)
			stepCount <= '0;
		else if (control.aluStart && isMulDiv)
			stepCount <= 6'd32;
		else if (stepCount != '0)
			stepCount <= stepCount - 6'd1;
	end

	assign aluDone = (stepCount == '0);

	// unsigned magnitudes, sign restored at the output
	always_ff @(posedge clock) begin
		if (control.aluStart && isMulDiv) begin
			accHi <= '0;
			accLo <= magA;
			operand <= magB;
			negHi <= ry[cpuPkg::wordWidth-1]; // remainder takes dividend sign
			negLo <= (ry[cpuPkg::wordWidth-1] ^ bus[cpuPkg::wordWidth-1]) && (bus != '0);
		end else if (stepCount != '0) begin
			if (!isDiv) begin
				accHi <= mulSum[cpuPkg::wordWidth:1]; // shift-add, one bit per cycle
				accLo <= {mulSum[0], accLo[cpuPkg::wordWidth-1:1]};
			end else if (!divDiff[cpuPkg::wordWidth]) begin
				accHi <= divDiff[cpuPkg::wordWidth-1:0]; // trial fits, keep it
				accLo <= {accLo[cpuPkg::wordWidth-2:0], 1'b1};
			end else begin
				accHi <= remShift[cpuPkg::wordWidth-1:0]; // restore
				accLo <= {accLo[cpuPkg::wordWidth-2:0], 1'b0};
			end
		end
	end

	// divide by zero ends with all ones and the dividend magnitude, negLo kept low
	assign mulDivResult = isDiv ? {negHi ? -accHi : accHi, negLo ? -accLo : accLo}
		: (negLo ? -{accHi, accLo} : {accHi, accLo});

	always_comb begin
		case (control.aluOp)
			cpuPkg::opAdd, cpuPkg::opAddi: single = ry + bus;
			cpuPkg::opSub: single = ry - bus;
			cpuPkg::opAnd, cpuPkg::opAndi: single = ry & bus;
			cpuPkg::opOr, cpuPkg::opOri: single = ry | bus;
			cpuPkg::opShr: single = ry >> shiftAmount;
			cpuPkg::opShra: single = $signed(ry) >>> shiftAmount;
			cpuPkg::opShl: single = ry << shiftAmount;
			cpuPkg::opRor: single = (ry >> shiftAmount) | (ry << rotBack);
			cpuPkg::opRol: single = (ry << shiftAmount) | (ry >> rotBack);
			cpuPkg::opNeg: single = -bus;
			cpuPkg::opNot: single = ~bus;
			default: single = '0;
		endcase
	end

	assign aluResult = isMulDiv ? mulDivResult : {{cpuPkg::wordWidth{1'b0}}, single};

endmodule

//--- design/memoryBlock.sv
`timescale 1ns/1ps

module memoryBlock (
	input  logic clock,
	input  logic reset,
	input  cpuPkg::controlWordT control,
	input  logic [cpuPkg::memAddrWidth-1:0] mar,
	input  logic [cpuPkg::wordWidth-1:0] mdr,
	input  logic loadValid,
	input  logic [cpuPkg::memAddrWidth-1:0] loadAddr,
	input  logic [cpuPkg::wordWidth-1:0] loadData,
	output logic [cpuPkg::wordWidth-1:0] memData
);

	logic [cpuPkg::wordWidth-1:0] mem [cpuPkg::memWords];

	always_ff @(posedge clock) begin
		if (reset && loadValid)
			mem[loadAddr] <= loadData; // program image, only while held in reset
		else if (control.memWrite)
			mem[mar] <= mdr; // st
	end

	assign memData = mem[mar]; // MDR samples this on memRead

	// loader must finish before the CPU leaves reset
	assert property (@(posedge clock) loadValid |-> reset);

endmodule

//--- design/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
	input  logic clock,
	input  logic reset,
	input  logic loadValid,
	input  logic [cpuPkg::memAddrWidth-1:0] loadAddr,
	input  logic [cpuPkg::wordWidth-1:0] loadData,
	input  logic [cpuPkg::wordWidth-1:0] inPort,
	output logic [cpuPkg::wordWidth-1:0] outPort,
	output logic outStrobe,
	output logic halted,
	output logic [15:0] instrCount
);

	cpuPkg::controlWordT control;
	logic [cpuPkg::wordWidth-1:0] ir;
	logic [cpuPkg::wordWidth-1:0] bus;
	logic [cpuPkg::wordWidth-1:0] regOut;
	logic [cpuPkg::wordWidth-1:0] ry;
	logic [cpuPkg::wordWidth-1:0] mdr;
	logic [cpuPkg::wordWidth-1:0] memData;
	logic [cpuPkg::memAddrWidth-1:0] mar;
	logic [2*cpuPkg::wordWidth-1:0] aluResult;
	logic branchTaken;
	logic aluDone;

	controlUnit control0 (
		.clock(clock), .reset(reset), .ir(ir), .branchTaken(branchTaken),
		.aluDone(aluDone), .control(control), .halted(halted), .instrCount(instrCount)
	);

	registerFile regs0 (
		.clock(clock), .reset(reset), .control(control), .ir(ir), .bus(bus), .regOut(regOut)
	);

	busDatapath path0 (
		.clock(clock), .reset(reset), .control(control), .regOut(regOut),
		.aluResult(aluResult), .memData(memData), .inPort(inPort), .bus(bus), .ir(ir),
		.ry(ry), .mar(mar), .mdr(mdr), .branchTaken(branchTaken), .outPort(outPort),
		.outStrobe(outStrobe)
	);

	aluUnit alu0 (
		.clock(clock), .reset(reset), .control(control), .ry(ry), .bus(bus),
		.aluResult(aluResult), .aluDone(aluDone)
	);

	memoryBlock mem0 (
		.clock(clock), .reset(reset), .control(control), .mar(mar), .mdr(mdr),
		.loadValid(loadValid), .loadAddr(loadAddr), .loadData(loadData), .memData(memData)
	);

endmodule

//--- tests/cpuChecker.sv
`timescale 1ns/1ps

module cpuChecker (
	input  logic clock,
	input  logic reset,
	input  logic [cpuPkg::wordWidth-1:0] outPort,
	input  logic outStrobe,
	input  logic halted,
	input  logic [15:0] instrCount,
	output int errorCount,
	output int outputCount
);

	localparam int expectBase = 'h80; // expected out values, in program order

	logic [cpuPkg::wordWidth-1:0] caseData [256];
	logic [15:0] expectedInstr;
	int expectedOutputs;
	logic haltSeen;

	initial begin
		$readmemh("tests/programCases.txt", caseData);
		expectedInstr = caseData[2][15:0];
		expectedOutputs = int'(caseData[3]);
	end

	always @(posedge clock or posedge reset) begin
		int newErrors;
		int seenOutputs;
		if (reset) begin
			errorCount <= 0;
			outputCount <= 0;
			haltSeen <= 1'b0;
		end else begin
			newErrors = 0;
			seenOutputs = outputCount;
			if (outStrobe) begin
				if (haltSeen) begin
					$display("out port strobed after halt, value %h", outPort);
					newErrors++;
				end else if (seenOutputs >= expectedOutputs) begin
					$display("extra output %h beyond the %0d expected", outPort, expectedOutputs);
					newErrors++;
				end else if (outPort !== caseData[expectBase + seenOutputs]) begin
					$display("CHECK FAILED at %0t: output %0d is %h, expected %h", $time,
						seenOutputs, outPort, caseData[expectBase + seenOutputs]);
					newErrors++;
				end
				seenOutputs++;
			end
			// first cycle of halt
			if (halted && !haltSeen) begin
				if (seenOutputs != expectedOutputs) begin
					$display("CHECK FAILED at %0t: %0d outputs at halt, expected %0d", $time,
						seenOutputs, expectedOutputs);
					newErrors++;
				end
				if (instrCount !== expectedInstr) begin
					$display("CHECK FAILED at %0t: instruction count %0d, expected %0d", $time,
						instrCount, expectedInstr);
					newErrors++;
				end
			end
			if (haltSeen && !halted) begin
				$display("halted flag dropped while reset was low");
				newErrors++;
			end
			haltSeen <= haltSeen | halted;
			outputCount <= seenOutputs;
			errorCount <= errorCount + newErrors;
		end
	end

endmodule

//--- tests/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;

	localparam int programBase = 'h10; // program image section of the cases file

	logic clock;
	logic reset;
	logic loadValid;
	logic [cpuPkg::memAddrWidth-1:0] loadAddr;
	logic [cpuPkg::wordWidth-1:0] loadData;
	logic [cpuPkg::wordWidth-1:0] inPort;
	logic [cpuPkg::wordWidth-1:0] outPort;
	logic outStrobe;
	logic halted;
	logic [15:0] instrCount;
	logic [cpuPkg::wordWidth-1:0] caseData [256];
	int errorCount; // from the checker
	int outputCount;
	int wordCount;
	int cycleLimit;
	int cycles;
	int failures;
	logic timedOut;

	cpuTop UUT (
		.clock(clock), .reset(reset), .loadValid(loadValid), .loadAddr(loadAddr),
		.loadData(loadData), .inPort(inPort), .outPort(outPort), .outStrobe(outStrobe),
		.halted(halted), .instrCount(instrCount)
	);

	cpuChecker checker0 (
		.clock(clock), .reset(reset), .outPort(outPort), .outStrobe(outStrobe),
		.halted(halted), .instrCount(instrCount), .errorCount(errorCount),
		.outputCount(outputCount)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock; // 4 ns period
	end

	// one RAM word per cycle while reset holds the CPU
	task automatic loadProgram();
		for (int i = 0; i < wordCount; i++) begin
			@(posedge clock);
			loadValid <= 1'b1;
			loadAddr <= i[cpuPkg::memAddrWidth-1:0];
			loadData <= caseData[programBase + i];
		end
		@(posedge clock);
		loadValid <= 1'b0;
	endtask

	// halted sampled mid cycle, away from the clock edge
	task automatic waitForHalt();
		cycles = 0;
		while (!halted && cycles < cycleLimit) begin
			@(negedge clock);
			cycles++;
		end
		timedOut = !halted;
	endtask

	initial begin
		reset = 1'b1;
		loadValid = 1'b0;
		loadAddr = '0;
		loadData = '0;
		inPort = '0;
		timedOut = 1'b0;
		$readmemh("tests/programCases.txt", caseData);
		wordCount = int'(caseData[0]);
		cycleLimit = 200 * wordCount + 2000; // generous per loaded word
		@(posedge clock);
		inPort <= caseData[1];
		loadProgram();
		repeat (10) @(posedge clock); // reset stays high 10 cycles past the load
		reset <= 1'b0;
		waitForHalt();
		if (timedOut)
			$display("program did not halt within %0d cycles", cycleLimit);
		else
			repeat (16) @(negedge clock); // room for a stray strobe after halt
		failures = errorCount + (timedOut ? 1 : 0);
		$display("%0d outputs seen, %0d errors", outputCount, failures);
		if (failures != 0) begin
			$display("TEST FAILED");
		end else begin
			$display("TEST OK");
		end
		$finish;
	end

endmodule

//--- tests/programCases.txt
// hex words by section. @000 header: program word count, in port value,
// executed instruction count, out value count. @010 program image. @080 out values
@000
0000005B CAFE1234 00000056 00000020
@010
08800064 0907FFF9 19890000 B9800000 21908000 B9800000 29890000 B9800000 // 00 ldi, add, sub, and
31890000 B9800000 0A000004 39920000 B9800000 41920000 B9800000 498A0000 // 08 or, shifts
B9800000 518A0000 B9800000 59920000 B9800000 618FFF38 B9800000 699000F0 // 10 rotates, addi, andi
B9800000 71880003 B9800000 89900000 B9800000 91880000 B9800000 11A00154 // 18 ori, neg, not, st
02800158 BA800000 0B012345 130800C8 0D000130 03D7FFFC BB800000 7B300000 // 20 ld, st, ld, mul
C5800000 CE000000 BD800000 BE000000 7B100000 C5800000 CE000000 BD800000 // 28 mfhi, mflo, mul
BE000000 80900000 C5800000 CE000000 BD800000 BE000000 81200000 C5800000 // 30 div
CE000000 BD800000 BE000000 81000000 C5800000 CE000000 BD800000 BE000000 // 38 div by zero
0E800BAD 0F00600D 98000001 BE800000 98800001 BF000000 98880001 BE800000 // 40 br zero, nonzero
98080001 B8800000 98900001 BE800000 99100001 BA000000 99180001 BE800000 // 48 br positive, negative
98180001 B9000000 0D000059 AD000000 D0000000 B4800000 BC800000 D8000000 // 50 jal, nop, in, halt
BE800000 BF800000 A7800000 // 58 subroutine at 0x59 outputs R15, jr back
@080
0000005D FFFFFF95 00000060 FFFFFFFD 0FFFFFFF FFFFFFFF 00000640 40000006
FFFFFF9F FFFFFF9C 000000F0 00000067 00000007 FFFFFF9B FFFFFF9B 00012345
00000001 4B65F099 FFFFFFFF FFF8091D 00000002 FFFFFFF2 FFFFFFFD FFFFFFFF
FFFFFFF9 FFFFFFFF 0000600D 00000064 00000004 FFFFFFF9 00000054 CAFE1234

//--- project.f
design/cpuPkg.sv
design/controlUnit.sv
design/registerFile.sv
design/busDatapath.sv
design/aluUnit.sv
design/memoryBlock.sv
design/cpuTop.sv
tests/cpuChecker.sv
tests/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpuTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TEST OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
